//--- src/dcache_defines.svh
/*
  cache geometry and ring slot codes
*/
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// direct mapped geometry
`define LINE_COUNT 128
`define WORDS_PER_LINE 8

// ring slot type codes
`define SLOT_ADDRESS 4'd1
`define SLOT_WRITE_DATA 4'd2

// bit positions inside an address slot
`define SLOT_EXCLUSIVE_BIT 29
`define SLOT_READ_BIT 28

`endif

//--- src/dcachePkg.sv
/*
  data cache types for word, address and tag vectors,
  line state and controller state enums
*/
`default_nettype none
`include "dcache_defines.svh"

package dcachePkg;

  typedef logic [31:0] wordT;
  typedef logic [$clog2(`LINE_COUNT * `WORDS_PER_LINE)-1:0] wordAddrT;
  typedef logic [$clog2(`LINE_COUNT)-1:0] lineIndexT;
  typedef logic [20:0] tagT;  // cpu address bits 30..10
  typedef logic [$clog2(`WORDS_PER_LINE)-1:0] wordCountT;
  typedef logic [3:0] coreIdT;
  typedef logic [3:0] slotTypeT;

  typedef enum logic [1:0] {
    INVALID  = 2'd0,
    SHARED   = 2'd1,  // clean copy for reads
    MODIFIED = 2'd3   // owned and dirty
  } lineStateT;

  typedef enum logic [2:0] {
    initSweep, idle, lookup, sendRequest,
    sendLineData, sendWriteAddress, resolve, invalidateLines
  } ctrlStateT;

  typedef enum logic [1:0] {noRefill, awaitWords, settle, ready} refillStateT;

endpackage

`default_nettype wire

//--- src/cachePorts.sv
/*
  tagPortIf for controller access to tags and line states
  dataPortIf for controller access to the data array
*/
`timescale 1ns/1ps
`default_nettype none

interface tagPortIf import dcachePkg::*; ();
  lineIndexT line;
  tagT       newTag;
  lineStateT newState;
  logic      writeTag;
  logic      writeState;
  tagT       tag;    // lookup result at line
  lineStateT state;

  modport controller (output line, newTag, newState, writeTag, writeState,
                      input tag, state);
  modport store (input line, newTag, newState, writeTag, writeState,
                 output tag, state);
endinterface

interface dataPortIf import dcachePkg::*; ();
  wordAddrT addr;
  wordT     writeData;
  logic     writeEnable;
  wordAddrT refillAddr;  // port B for refills only
  wordT     refillData;
  logic     refillEnable;
  wordT     readData;    // one clock behind addr

  modport controller (output addr, writeData, writeEnable, refillAddr, refillData,
                      refillEnable, input readData);
  modport store (input addr, writeData, writeEnable, refillAddr, refillData,
                 refillEnable, output readData);
endinterface

`default_nettype wire

//--- src/tagStore.sv
/*
  tag and line state arrays
  one combinational lookup at line, writes at the clock edge
*/
`timescale 1ns/1ps
`default_nettype none

module tagStore import dcachePkg::*; (
  input logic clock,
  input logic reset,
  tagPortIf.store tags
);

  localparam int depth = 1 << $bits(lineIndexT);

  tagT       tagArray [depth];
  lineStateT stateArray [depth];

  // writes wait until reset is released
  always_ff @(posedge clock) begin
    if (!reset) begin
      if (tags.writeTag)
        tagArray[tags.line] <= tags.newTag;
      if (tags.writeState)
        stateArray[tags.line] <= tags.newState;
    end
  end

  assign tags.tag   = tagArray[tags.line];    // distributed ram style read
  assign tags.state = stateArray[tags.line];

endmodule

`default_nettype wire

//--- src/dataStore.sv
/*
  data array, 1024 words
  port A for cpu and write-back access with registered read address
  port B for refill writes from the read return bus
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module dataStore import dcachePkg::*; (
  input logic clock,
  dataPortIf.store data
);

  wordT     words [`LINE_COUNT * `WORDS_PER_LINE];
  wordAddrT readAddr;

  always_ff @(posedge clock) begin
    readAddr <= data.addr;  // bram style sync read
    if (data.writeEnable)
      words[data.addr] <= data.writeData;
    // refill comes last so it wins a same-address clash
    if (data.refillEnable)
      words[data.refillAddr] <= data.refillData;
  end

  assign data.readData = words[readAddr];

endmodule

`default_nettype wire

//--- src/lineCounters.sv
/*
  refill word counter, write-back word counter
  and line down counter for the sweep and invalidate range
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module lineCounters import dcachePkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      startRefill,
  input  logic      refillWord,
  input  logic      startFlush,
  input  logic      flushWord,
  input  logic      loadLines,
  input  lineIndexT lineTotal,
  input  logic      stepLine,
  output wordCountT refillCount,
  output wordCountT flushCount,
  output lineIndexT lineCount
);

  always_ff @(posedge clock) begin
    if (reset) begin
      refillCount <= '0;
      flushCount  <= '0;
      lineCount   <= lineIndexT'(`LINE_COUNT - 1);  // sweep starts from the top line
    end else begin
      if (startRefill) refillCount <= '0;
      else if (refillWord) refillCount <= refillCount + 1'b1;

      if (startFlush) flushCount <= '0;
      else if (flushWord) flushCount <= flushCount + 1'b1;

      if (loadLines) lineCount <= lineTotal;
      else if (stepLine) lineCount <= lineCount - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/cacheController.sv
/*
  cache controller with command FSM, hit check, refill tracker,
  ring slot selection and data array addressing
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module cacheController import dcachePkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        read,
  input  logic        selDCache,
  input  logic        selDCacheIO,
  input  logic        dcAcquireToken,
  input  logic [30:0] aq,
  input  wordT        wq,
  input  coreIdT      whichCore,
  input  coreIdT      rdDest,
  input  wordT        rdReturn,
  output logic        rwq,
  output logic        wrq,
  output logic        done,
  output logic        decLineAddr,
  output logic        dcDriveRing,
  output logic        dcWantsToken,
  output wordT        dcRingOut,
  output slotTypeT    dcSlotTypeOut,
  tagPortIf.controller  tags,
  dataPortIf.controller data,
  output logic        startRefill,
  output logic        refillWord,
  output logic        startFlush,
  output logic        flushWord,
  output logic        loadLines,
  output lineIndexT   lineTotal,
  output logic        stepLine,
  input  wordCountT   refillCount,
  input  wordCountT   flushCount,
  input  lineIndexT   lineCount
);

  localparam wordCountT lastWord = wordCountT'(`WORDS_PER_LINE - 1);

  ctrlStateT   state;
  refillStateT refillState;
  logic        doWriteBack;  // victim is dirty
  wordT        requestWord, writeAddrWord, requestNext;
  logic        hit, miss, finishing, tokenSlot, ownWord;
  lineIndexT   line;

  assign line = aq[9:3];

  assign hit = (tags.tag == aq[30:10]) &&
               (read ? tags.state != INVALID : tags.state == MODIFIED);
  assign miss = (state == lookup) && !hit;

  // read address slot for the pending miss
  always_comb begin
    requestNext = {4'b0000, aq[30:3]};
    requestNext[`SLOT_READ_BIT] = 1'b1;
    requestNext[`SLOT_EXCLUSIVE_BIT] = ~read;  // writes ask for ownership
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= initSweep;
      doWriteBack <= 1'b0;
    end else begin
      case (state)
        initSweep: if (lineCount == '0) state <= idle;
        idle: begin
          if (selDCache) state <= lookup;
          else if (selDCacheIO) state <= invalidateLines;
        end
        lookup: begin
          doWriteBack <= !hit && tags.state == MODIFIED;
          state <= hit ? resolve : sendRequest;
        end
        sendRequest:
          if (dcAcquireToken) state <= doWriteBack ? sendLineData : resolve;
        sendLineData: if (flushCount == lastWord) state <= sendWriteAddress;
        sendWriteAddress: state <= resolve;
        resolve: if (finishing) state <= idle;
        invalidateLines: if (lineCount == '0) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == lookup) begin
      requestWord   <= requestNext;
      writeAddrWord <= {4'b0000, tags.tag, line};  // read bit stays clear
    end
  end

  // refill tracker runs beside the FSM while the write-back may still be going
  assign ownWord = (refillState == awaitWords) && (rdDest == whichCore);

  always_ff @(posedge clock) begin
    if (reset) begin
      refillState <= noRefill;
    end else begin
      case (refillState)
        noRefill: if (miss) refillState <= awaitWords;
        awaitWords: if (ownWord && refillCount == lastWord) refillState <= settle;
        settle: refillState <= ready;  // last word lands in the array
        ready: if (state == resolve) refillState <= noRefill;
        default: refillState <= noRefill;
      endcase
    end
  end

  assign startRefill = miss;
  assign refillWord  = ownWord;
  assign startFlush  = miss;
  assign flushWord   = (state == sendLineData);
  assign loadLines   = (state == idle) && !selDCache && selDCacheIO;
  assign lineTotal   = aq[16:10];
  assign stepLine    = (state == initSweep) ||
                       (state == invalidateLines && lineCount != '0);

  // hits pass straight through, misses wait for the refill
  assign finishing = (state == resolve) &&
                     (refillState == noRefill || refillState == ready);

  assign done = finishing || (state == invalidateLines && lineCount == '0);
  assign wrq  = finishing && read;
  assign rwq  = finishing && !read;
  assign decLineAddr = (state == invalidateLines) && (lineCount != '0);

  // tag and state port
  assign tags.line   = (state == initSweep) ? lineCount : line;
  assign tags.newTag = aq[30:10];
  assign tags.writeTag = miss;
  always_comb begin
    tags.newState = INVALID;  // sweep, invalidate, miss in flight
    if (state == resolve) tags.newState = read ? SHARED : MODIFIED;
  end
  assign tags.writeState = (state == initSweep) || miss ||
                           (finishing && refillState == ready) ||
                           (state == invalidateLines && tags.state != MODIFIED);

  // data port reads one word ahead while writing back
  always_comb begin
    data.addr = aq[9:0];
    if (state == sendRequest) data.addr = {line, flushCount};
    else if (state == sendLineData) data.addr = {line, wordCountT'(flushCount + 1'b1)};
  end
  assign data.writeData    = wq;
  assign data.writeEnable  = finishing && !read;
  assign data.refillAddr   = {line, refillCount};
  assign data.refillData   = rdReturn;
  assign data.refillEnable = ownWord;

  // ring side
  assign tokenSlot    = (state == sendRequest) && dcAcquireToken;
  assign dcWantsToken = (state == sendRequest);
  assign dcDriveRing  = tokenSlot || state == sendLineData || state == sendWriteAddress;

  always_comb begin
    dcRingOut     = '0;
    dcSlotTypeOut = '0;
    if (tokenSlot) begin
      dcRingOut     = requestWord;
      dcSlotTypeOut = `SLOT_ADDRESS;
    end else if (state == sendLineData) begin
      dcRingOut     = data.readData;
      dcSlotTypeOut = `SLOT_WRITE_DATA;
    end else if (state == sendWriteAddress) begin
      dcRingOut     = writeAddrWord;
      dcSlotTypeOut = `SLOT_ADDRESS;
    end
  end

endmodule

`default_nettype wire

//--- src/coherentDCache.sv
/*
  coherent data cache top level
  controller, tag store, data store and counters
*/
`timescale 1ns/1ps
`default_nettype none

module coherentDCache import dcachePkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        read,
  input  logic        selDCache,
  input  logic        selDCacheIO,
  input  logic        dcAcquireToken,
  input  logic [30:0] aq,
  input  wordT        wq,
  input  coreIdT      whichCore,
  input  wordT        RDreturn,
  input  coreIdT      RDdest,
  output logic        rwq,
  output logic        wrq,
  output logic        done,
  output logic        decLineAddr,
  output logic        dcDriveRing,
  output logic        dcWantsToken,
  output wordT        rqDCache,
  output wordT        dcRingOut,
  output slotTypeT    dcSlotTypeOut,
  output coreIdT      dcSourceOut
);

  tagPortIf  tagBus ();
  dataPortIf dataBus ();

  logic      startRefill, refillWord, startFlush, flushWord, loadLines, stepLine;
  lineIndexT lineTotal, lineCount;
  wordCountT refillCount, flushCount;

  assign rqDCache    = dataBus.readData;
  assign dcSourceOut = whichCore;  // every slot we add is ours

  cacheController controller (
    .clock, .reset, .read, .selDCache, .selDCacheIO, .dcAcquireToken,
    .aq, .wq, .whichCore,
    .rdDest(RDdest),
    .rdReturn(RDreturn),
    .rwq, .wrq, .done, .decLineAddr, .dcDriveRing, .dcWantsToken,
    .dcRingOut, .dcSlotTypeOut,
    .tags(tagBus.controller),
    .data(dataBus.controller),
    .startRefill, .refillWord, .startFlush, .flushWord,
    .loadLines, .lineTotal, .stepLine,
    .refillCount, .flushCount, .lineCount
  );

  tagStore tagArrays (
    .clock, .reset,
    .tags(tagBus.store)
  );

  dataStore dataArray (
    .clock,
    .data(dataBus.store)
  );

  lineCounters counters (
    .clock, .reset,
    .startRefill, .refillWord, .startFlush, .flushWord,
    .loadLines, .lineTotal, .stepLine,
    .refillCount, .flushCount, .lineCount
  );

endmodule

`default_nettype wire

//--- bench/dcacheBench.sv
/*
  testbench for the coherent data cache with golden record reader,
  token and memory model, ring monitor and checks
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module dcacheBench;
  import dcachePkg::*;

  localparam coreIdT otherCore = 4'd9;
  localparam wordT memPattern = 32'h5e400000;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic read = 1'b0;
  logic selDCache = 1'b0;
  logic selDCacheIO = 1'b0;
  logic dcAcquireToken = 1'b0;
  logic [30:0] aq = '0;
  wordT wq = '0;
  coreIdT whichCore = 4'd3;
  wordT RDreturn = '0;
  coreIdT RDdest = 4'd9;
  logic rwq, wrq, done, decLineAddr, dcDriveRing, dcWantsToken;
  wordT rqDCache, dcRingOut;
  slotTypeT dcSlotTypeOut;
  coreIdT dcSourceOut;

  logic [31:0] golden [0:159];
  wordT refMem [logic [30:0]];   // what the cpu has written
  wordT shadow [logic [30:0]];   // memory contents after write-backs
  wordT wbWords [8];
  logic [20:0] lineTag [128];    // address held by each line after its last miss
  logic [20:0] victimTag = '0;
  logic [31:0] randState = 32'h5e40;
  logic [1:0] tokenWait = 2'd0;
  logic [27:0] replyLine = '0;
  int cycle = 0;
  int replyAt = -1000;
  int timeoutLimit = 100000;
  int requestCount = 0;
  int writeBackCount = 0;
  int wbCount = 0;
  int opErrors = 0;
  int ringErrors = 0;
  int recordCount = 0;
  logic opActive = 1'b0;

  coherentDCache uut (.*);

  always #2 clock = ~clock;

  function automatic logic [31:0] nextRand(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic wordT memWord(input logic [30:0] a);
    if (shadow.exists(a)) return shadow[a];
    return {1'b0, a} ^ memPattern;
  endfunction

  function automatic wordT cpuWord(input logic [30:0] a);
    if (refMem.exists(a)) return refMem[a];
    return {1'b0, a} ^ memPattern;
  endfunction

  // token grant after 0..3 cycles and refill words 12 cycles after a request
  always @(posedge clock) begin : ringModel
    int offset;
    cycle <= cycle + 1;
    if (reset || !dcWantsToken || dcAcquireToken) begin
      dcAcquireToken <= 1'b0;
      randState = nextRand(randState);
      tokenWait <= randState[17:16];
    end else if (tokenWait == 2'd0) begin
      dcAcquireToken <= 1'b1;
    end else begin
      tokenWait <= tokenWait - 1'b1;
    end
    offset = cycle - replyAt;
    if (offset >= 0 && offset < 8) begin
      RDdest   <= whichCore;
      RDreturn <= memWord({replyLine, offset[2:0]});
    end else begin
      RDdest   <= otherCore;  // traffic for someone else
      RDreturn <= randState;
    end
  end

  always @(posedge clock) begin
    if (cycle > timeoutLimit) begin
      $display("timeout after %0d cycles, the cache stopped answering", cycle);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ring monitor and idle checks
  always @(negedge clock) begin
    if (!reset) begin
      assert (dcSourceOut == whichCore) else begin
        $display("mismatch at %0t: dcSourceOut got %h expected %h", $time, dcSourceOut,
                 whichCore);
        ringErrors++;
      end
      if (dcDriveRing) begin
        assert (dcSlotTypeOut == `SLOT_ADDRESS || dcSlotTypeOut == `SLOT_WRITE_DATA)
        else begin
          $display("unexpected ring slot type %h at %0t", dcSlotTypeOut, $time);
          ringErrors++;
        end
        if (dcSlotTypeOut == `SLOT_ADDRESS && dcRingOut[`SLOT_READ_BIT]) begin
          requestCount++;
          wbCount = 0;
          replyLine = dcRingOut[27:0];
          replyAt = cycle + 12;
          victimTag = lineTag[aq[9:3]];
          lineTag[aq[9:3]] = aq[30:10];
          assert (dcRingOut == {2'b00, !read, 1'b1, aq[30:3]}) else begin
            $display("mismatch at %0t: dcRingOut got %h expected %h", $time, dcRingOut,
                     {2'b00, !read, 1'b1, aq[30:3]});
            ringErrors++;
          end
        end else if (dcSlotTypeOut == `SLOT_WRITE_DATA) begin
          if (wbCount < 8) wbWords[wbCount] = dcRingOut;
          wbCount++;
        end else if (dcSlotTypeOut == `SLOT_ADDRESS) begin
          writeBackCount++;
          assert (wbCount == 8) else begin
            $display("write-back at %0t sent %0d data slots instead of 8", $time, wbCount);
            ringErrors++;
          end
          assert (dcRingOut == {4'b0000, victimTag, aq[9:3]}) else begin
            $display("mismatch at %0t: dcRingOut got %h expected %h", $time, dcRingOut,
                     {4'b0000, victimTag, aq[9:3]});
            ringErrors++;
          end
          for (int i = 0; i < 8; i++) begin
            assert (wbWords[i] == cpuWord({victimTag, aq[9:3], i[2:0]})) else begin
              $display("mismatch at %0t: dcRingOut write-back word %0d got %h expected %h",
                       $time, i, wbWords[i], cpuWord({victimTag, aq[9:3], i[2:0]}));
              ringErrors++;
            end
            shadow[{victimTag, aq[9:3], i[2:0]}] = wbWords[i];
          end
        end
      end
      if (!opActive) begin
        assert (!(done || wrq || rwq || decLineAddr || dcDriveRing || dcWantsToken)) else begin
          $display("cache active at %0t with no operation pending", $time);
          ringErrors++;
        end
      end
    end
  end

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
    opErrors++;
  endtask

  task automatic reportProblem(input string text);
    $display("error at %0t: %s", $time, text);
    opErrors++;
  endtask

  // op 0 read, 1 write, 2 invalidate; kind 0 miss, 1 hit, 2 miss with write-back
  task automatic runRecord(input int idx);
    logic [31:0] op, addr, wdata, expected, kind;
    int cycles, pulses, reqBefore, wbBefore, errBefore, lines;
    int reqExpected, wbExpected;
    logic decSeen, seenWrq, seenRwq, ringSeen;
    wordT seenData;
    op = golden[5 * idx];
    addr = golden[5 * idx + 1];
    wdata = golden[5 * idx + 2];
    expected = golden[5 * idx + 3];
    kind = golden[5 * idx + 4];
    errBefore = opErrors + ringErrors;
    reqBefore = requestCount;
    wbBefore = writeBackCount;
    reqExpected = (kind == 1) ? 0 : 1;
    wbExpected = (kind == 2) ? 1 : 0;
    cycles = 0;
    pulses = 0;
    decSeen = 1'b0;
    ringSeen = 1'b0;
    @(posedge clock);
    opActive = 1'b1;
    aq <= addr[30:0];
    wq <= wdata;
    read <= (op == 0);
    selDCache <= (op != 2);
    selDCacheIO <= (op == 2);
    do begin
      @(posedge clock);
      selDCache <= 1'b0;
      selDCacheIO <= 1'b0;
      if (decSeen) aq[9:3] <= aq[9:3] - 1'b1;  // cpu steps to the next line
      cycles++;
      @(negedge clock);
      decSeen = decLineAddr;
      if (decLineAddr) pulses++;
      if (dcDriveRing || dcWantsToken) ringSeen = 1'b1;
    end while (!done);
    seenWrq = wrq;
    seenRwq = rwq;
    seenData = rqDCache;
    @(posedge clock);
    opActive = 1'b0;
    if (op == 0) begin
      assert (seenWrq && !seenRwq) else reportProblem("read finished without wrq alone");
      assert (seenData == expected) else reportMismatch("rqDCache", seenData, expected);
    end else if (op == 1) begin
      assert (seenRwq && !seenWrq) else reportProblem("write finished without rwq alone");
      refMem[addr[30:0]] = wdata;
    end else begin
      lines = int'(addr[16:10]);
      assert (pulses == lines) else reportMismatch("decLineAddr pulses", pulses, lines);
      assert (cycles == lines + 1) else reportMismatch("done cycle", cycles, lines + 1);
    end
    if (op != 2) begin
      assert (requestCount - reqBefore == reqExpected)
        else reportMismatch("read-address slots", requestCount - reqBefore, reqExpected);
      assert (writeBackCount - wbBefore == wbExpected)
        else reportMismatch("write-backs", writeBackCount - wbBefore, wbExpected);
      if (kind == 1) begin
        assert (cycles == 2) else reportMismatch("hit latency", cycles, 2);
        assert (!ringSeen) else reportProblem("hit drove the ring or asked for the token");
      end
    end
    $display("record %0d op %0d addr %h: %s", idx, op, addr,
             (opErrors + ringErrors == errBefore) ? "ok" : "failed");
  endtask

  initial begin
    $readmemh("bench/dcache_golden.txt", golden);
    while (recordCount < 32 && golden[5 * recordCount] != 32'hf) recordCount++;
    timeoutLimit = 200 + 80 * recordCount;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    repeat (130) @(posedge clock);  // reset sweep of all lines
    for (int i = 0; i < recordCount; i++) runRecord(i);
    $display("records %0d, failed checks %0d", recordCount, opErrors + ringErrors);
    if (opErrors + ringErrors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/dcache_golden.txt
// op (0 read, 1 write, 2 invalidate)  address  write data  expected read  kind
// kind: 0 miss, 1 hit, 2 miss with victim write-back; op f ends the list
0 00001234 00000000 5e401234 0
0 00001234 00000000 5e401234 1
0 00001235 00000000 5e401235 1
1 00001236 cafe0001 00000000 0
0 00001236 00000000 cafe0001 1
1 00001230 cafe0002 00000000 1
0 00005234 00000000 5e405234 2
0 00001236 00000000 cafe0001 0
1 00001240 beef0003 00000000 0
0 00001238 00000000 5e401238 0
2 00000a40 00000000 00000000 0
0 00001240 00000000 beef0003 1
0 00001238 00000000 5e401238 0
0 00001236 00000000 cafe0001 0
0 00001244 00000000 5e401244 1
1 00001244 12345678 00000000 1
0 00001244 00000000 12345678 1
f 00000000 00000000 00000000 0

//--- vlog.f
+incdir+src
src/dcachePkg.sv
src/cachePorts.sv
src/tagStore.sv
src/dataStore.sv
src/lineCounters.sv
src/cacheController.sv
src/coherentDCache.sv
bench/dcacheBench.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; passes only if the output holds the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module dcacheBench -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "TEST PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
